/* logic/icache_pkg.sv */
/*
 * Instruction cache lookup package
 * Default geometry, the tag width helper and the shared enums
 */
`default_nettype none

package icache_pkg;

  // Default geometry, overridden at the top level
  localparam int unsigned DefSetCount  = 4;
  localparam int unsigned DefLineCount = 16;
  localparam int unsigned DefLineWidth = 64;
  localparam int unsigned DefFetchAw   = 32;
  localparam int unsigned DefIdWidth   = 4;

  // Operation on the shared tag port in one cycle
  typedef enum logic [1:0] {
    TAG_OP_IDLE,
    TAG_OP_CLEAR,
    TAG_OP_REFILL,
    TAG_OP_LOOKUP
  } tag_op_e;

  // Init and flush sweep
  typedef enum logic {
    ST_SWEEP,
    ST_READY
  } init_state_e;

  // Address bits above line offset and line index
  function automatic int unsigned tag_width(input int unsigned fetch_aw,
                                            input int unsigned line_width,
                                            input int unsigned line_count);
    return fetch_aw - $clog2(line_width / 8) - $clog2(line_count);
  endfunction

endpackage

`default_nettype wire

/* logic/icache_tag_ctrl.sv */
/*
 * Tag controller
 * Runs the clear sweep, arbitrates the shared tag port and
 * holds the request of the tag stage
 */
`default_nettype none

module icache_tag_ctrl #(
  parameter int unsigned SET_COUNT   = icache_pkg::DefSetCount,
  parameter int unsigned LINE_COUNT  = icache_pkg::DefLineCount,
  parameter int unsigned LINE_WIDTH  = icache_pkg::DefLineWidth,
  parameter int unsigned FETCH_AW    = icache_pkg::DefFetchAw,
  parameter int unsigned ID_WIDTH    = icache_pkg::DefIdWidth,
  localparam int unsigned LINE_ALIGN  = $clog2(LINE_WIDTH / 8),
  localparam int unsigned COUNT_ALIGN = $clog2(LINE_COUNT),
  localparam int unsigned SET_ALIGN   = $clog2(SET_COUNT)
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic [FETCH_AW-1:0]     in_addr_i,
  input  logic [ID_WIDTH-1:0]     in_id_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  logic                    write_valid_i,
  input  logic [COUNT_ALIGN-1:0]  write_addr_i,
  input  logic [SET_ALIGN-1:0]    write_set_i,
  output logic                    write_ready_o,
  input  logic                    stage_ready_i,
  output icache_pkg::tag_op_e     tag_op_o,
  output logic [COUNT_ALIGN-1:0]  tag_index_o,
  output logic [SET_COUNT-1:0]    set_enable_o,
  output logic [FETCH_AW-1:0]     req_addr_o,
  output logic [ID_WIDTH-1:0]     req_id_o,
  output logic                    req_valid_o
);

  icache_pkg::init_state_e state_q;
  logic [COUNT_ALIGN-1:0]  count_q;
  logic                    refill_grant;
  logic                    lookup_grant;

  // ------------------------------------------------------------
  // Sweep clearing one line per cycle over all sets
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= icache_pkg::ST_SWEEP;
      count_q <= '0;
    end else begin
      case (state_q)
        icache_pkg::ST_SWEEP: begin
          count_q <= count_q + 1'b1;
          if (count_q == COUNT_ALIGN'(LINE_COUNT - 1)) begin
            state_q <= icache_pkg::ST_READY;
          end
        end
        icache_pkg::ST_READY: begin
          // A flush during a sweep is absorbed by that sweep
          if (flush_i) begin
            state_q <= icache_pkg::ST_SWEEP;
            count_q <= '0;
          end
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Tag port arbitration
  // ------------------------------------------------------------
  assign write_ready_o = (state_q == icache_pkg::ST_READY);
  assign refill_grant  = write_valid_i && write_ready_o;
  // Refills take the port and lookups wait for room in the tag stage
  assign in_ready_o    = write_ready_o && !write_valid_i && stage_ready_i;
  assign lookup_grant  = in_valid_i && in_ready_o;

  always_comb begin
    tag_op_o     = icache_pkg::TAG_OP_IDLE;
    tag_index_o  = in_addr_i[LINE_ALIGN +: COUNT_ALIGN];
    set_enable_o = '0;
    if (state_q == icache_pkg::ST_SWEEP) begin
      tag_op_o     = icache_pkg::TAG_OP_CLEAR;
      tag_index_o  = count_q;
      set_enable_o = '1;
    end else if (refill_grant) begin
      tag_op_o                  = icache_pkg::TAG_OP_REFILL;
      tag_index_o               = write_addr_i;
      set_enable_o[write_set_i] = 1'b1;
    end else if (lookup_grant) begin
      tag_op_o     = icache_pkg::TAG_OP_LOOKUP;
      set_enable_o = '1;
    end
  end

  // Tag stage request register
  always_ff @(posedge clk_i) begin
    if (lookup_grant) begin
      req_addr_o <= in_addr_i;
      req_id_o   <= in_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_o <= 1'b0;
    end else if (lookup_grant) begin
      req_valid_o <= 1'b1;
    end else if (stage_ready_i) begin
      req_valid_o <= 1'b0;
    end
  end

  // A refill and a lookup moving on to the data port never share a cycle
  a_single_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_grant && req_valid_o |-> !stage_ready_i);

endmodule

`default_nettype wire

/* logic/icache_tag_way.sv */
/*
 * Tag way
 * Tag memory of one set and the compare against the tag stage request
 */
`default_nettype none

module icache_tag_way #(
  parameter int unsigned LINE_COUNT  = icache_pkg::DefLineCount,
  parameter int unsigned LINE_WIDTH  = icache_pkg::DefLineWidth,
  parameter int unsigned FETCH_AW    = icache_pkg::DefFetchAw,
  localparam int unsigned COUNT_ALIGN = $clog2(LINE_COUNT),
  localparam int unsigned TAG_WIDTH   =
    icache_pkg::tag_width(FETCH_AW, LINE_WIDTH, LINE_COUNT)
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  icache_pkg::tag_op_e     tag_op_i,
  input  logic [COUNT_ALIGN-1:0]  tag_index_i,
  input  logic                    enable_i,
  input  logic [TAG_WIDTH-1:0]    wr_tag_i,
  input  logic                    wr_error_i,
  input  logic [FETCH_AW-1:0]     req_addr_i,
  output logic                    way_hit_o,
  output logic                    way_error_o
);

  // Entry layout {valid, error, tag}
  logic [TAG_WIDTH+1:0] mem_q [LINE_COUNT];
  logic [TAG_WIDTH+1:0] wdata;
  logic                 mem_write;
  logic                 mem_read;
  logic                 rd_valid_q;
  logic                 rd_error_q;
  logic [TAG_WIDTH-1:0] rd_tag_q;

  assign mem_write = enable_i && (tag_op_i == icache_pkg::TAG_OP_CLEAR ||
                                  tag_op_i == icache_pkg::TAG_OP_REFILL);
  assign mem_read  = enable_i && (tag_op_i == icache_pkg::TAG_OP_LOOKUP);
  // Clear writes an invalid entry
  assign wdata = (tag_op_i == icache_pkg::TAG_OP_REFILL) ? {1'b1, wr_error_i, wr_tag_i} : '0;

  always_ff @(posedge clk_i) begin
    if (mem_write) begin
      mem_q[tag_index_i] <= wdata;
    end
    if (mem_read) begin
      rd_error_q <= mem_q[tag_index_i][TAG_WIDTH];
      rd_tag_q   <= mem_q[tag_index_i][TAG_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
    end else if (mem_read) begin
      rd_valid_q <= mem_q[tag_index_i][TAG_WIDTH+1];
    end
  end

  // Read result holds until the next lookup
  assign way_hit_o   = rd_valid_q && (rd_tag_q == req_addr_i[FETCH_AW-1 -: TAG_WIDTH]);
  assign way_error_o = way_hit_o && rd_error_q;

endmodule

`default_nettype wire

/* logic/icache_hit_select.sv */
/*
 * Hit selector
 * Encodes the hit set, holds the tag response while the data stage
 * stalls and drops a hit whose line is refilled meanwhile
 */
`default_nettype none

module icache_hit_select #(
  parameter int unsigned SET_COUNT   = icache_pkg::DefSetCount,
  parameter int unsigned LINE_COUNT  = icache_pkg::DefLineCount,
  localparam int unsigned SET_ALIGN   = $clog2(SET_COUNT),
  localparam int unsigned COUNT_ALIGN = $clog2(LINE_COUNT)
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [SET_COUNT-1:0]    way_hit_i,
  input  logic [SET_COUNT-1:0]    way_error_i,
  input  logic                    req_valid_i,
  input  logic [COUNT_ALIGN-1:0]  req_index_i,
  input  logic                    refill_valid_i,
  input  logic [COUNT_ALIGN-1:0]  refill_index_i,
  input  logic [SET_ALIGN-1:0]    refill_set_i,
  input  logic                    tag_ready_i,
  output logic                    tag_valid_o,
  output logic                    hit_o,
  output logic [SET_ALIGN-1:0]    hit_set_o,
  output logic                    error_o,
  output logic                    stage_ready_o,
  output logic                    event_hit_o,
  output logic                    event_miss_o
);

  logic                 held_q;
  logic                 fresh;
  logic                 hit_s, error_s;
  logic [SET_ALIGN-1:0] set_s;
  logic                 hit_d, error_d;
  logic [SET_ALIGN-1:0] set_d;
  logic                 hit_q, error_q;
  logic [SET_ALIGN-1:0] set_q;

  // Lowest-numbered hitting set wins
  always_comb begin
    hit_s   = |way_hit_i;
    error_s = |(way_hit_i & way_error_i);
    set_s   = '0;
    for (int i = SET_COUNT - 1; i >= 0; i--) begin
      if (way_hit_i[i]) begin
        set_s = SET_ALIGN'(i);
      end
    end
  end

  // Ways present a new result in the first cycle of a request
  assign fresh = req_valid_i && !held_q;

  assign tag_valid_o   = req_valid_i;
  assign stage_ready_o = !req_valid_i || tag_ready_i;
  assign hit_o         = fresh ? hit_s   : hit_q;
  assign hit_set_o     = fresh ? set_s   : set_q;
  assign error_o       = fresh ? error_s : error_q;
  assign event_hit_o   = fresh && hit_s;
  assign event_miss_o  = fresh && !hit_s;

  always_comb begin
    hit_d   = hit_q;
    set_d   = set_q;
    error_d = error_q;
    if (fresh) begin
      hit_d   = hit_s;
      set_d   = set_s;
      error_d = error_s;
    end
    // Refill into the line we are about to read
    if (refill_valid_i && refill_index_i == req_index_i && refill_set_i == hit_set_o) begin
      hit_d   = 1'b0;
      error_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    hit_q   <= hit_d;
    set_q   <= set_d;
    error_q <= error_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
    end else begin
      held_q <= req_valid_i && !tag_ready_i;
    end
  end

endmodule

`default_nettype wire

/* logic/icache_data_stage.sv */
/*
 * Data stage
 * Line memory shared with refills, output register and read buffer
 */
`default_nettype none

module icache_data_stage #(
  parameter int unsigned SET_COUNT   = icache_pkg::DefSetCount,
  parameter int unsigned LINE_COUNT  = icache_pkg::DefLineCount,
  parameter int unsigned LINE_WIDTH  = icache_pkg::DefLineWidth,
  parameter int unsigned FETCH_AW    = icache_pkg::DefFetchAw,
  parameter int unsigned ID_WIDTH    = icache_pkg::DefIdWidth,
  localparam int unsigned LINE_ALIGN  = $clog2(LINE_WIDTH / 8),
  localparam int unsigned COUNT_ALIGN = $clog2(LINE_COUNT),
  localparam int unsigned SET_ALIGN   = $clog2(SET_COUNT)
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    tag_valid_i,
  output logic                    tag_ready_o,
  input  logic                    hit_i,
  input  logic [SET_ALIGN-1:0]    hit_set_i,
  input  logic                    error_i,
  input  logic [FETCH_AW-1:0]     req_addr_i,
  input  logic [ID_WIDTH-1:0]     req_id_i,
  input  logic                    refill_valid_i,
  input  logic [COUNT_ALIGN-1:0]  refill_index_i,
  input  logic [SET_ALIGN-1:0]    refill_set_i,
  input  logic [LINE_WIDTH-1:0]   write_data_i,
  output logic [FETCH_AW-1:0]     out_addr_o,
  output logic [ID_WIDTH-1:0]     out_id_o,
  output logic [SET_ALIGN-1:0]    out_set_o,
  output logic                    out_hit_o,
  output logic [LINE_WIDTH-1:0]   out_data_o,
  output logic                    out_error_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i
);

  logic [LINE_WIDTH-1:0]            mem_q [SET_COUNT * LINE_COUNT];
  logic [SET_ALIGN+COUNT_ALIGN-1:0] mem_addr;
  logic                             mem_en;
  logic                             mem_we;
  logic [LINE_WIDTH-1:0]            rdata_q;
  logic [LINE_WIDTH-1:0]            rbuf_q;
  logic                             tag_hs;
  logic                             rd_fresh_q;
  logic                             valid_q;

  // ------------------------------------------------------------
  // Single-port line memory
  // ------------------------------------------------------------
  assign tag_ready_o = (!valid_q || out_ready_i) && !refill_valid_i;
  assign tag_hs      = tag_valid_i && tag_ready_o;

  always_comb begin
    mem_en   = tag_hs && hit_i;
    mem_we   = 1'b0;
    mem_addr = {hit_set_i, req_addr_i[LINE_ALIGN +: COUNT_ALIGN]};
    if (refill_valid_i) begin
      mem_en   = 1'b1;
      mem_we   = 1'b1;
      mem_addr = {refill_set_i, refill_index_i};
    end
  end

  // Read-first, so a write also replaces the read register
  always_ff @(posedge clk_i) begin
    if (mem_en) begin
      if (mem_we) begin
        mem_q[mem_addr] <= write_data_i;
      end
      rdata_q <= mem_q[mem_addr];
    end
  end

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= 1'b0;
      rd_fresh_q <= 1'b0;
    end else begin
      rd_fresh_q <= tag_hs && hit_i;
      if (tag_hs) begin
        valid_q <= 1'b1;
      end else if (out_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_hs) begin
      out_addr_o  <= req_addr_i;
      out_id_o    <= req_id_i;
      out_set_o   <= hit_set_i;
      out_hit_o   <= hit_i;
      out_error_o <= error_i;
    end
    // Keep the line before a refill can overwrite the read register
    if (rd_fresh_q && !out_ready_i) begin
      rbuf_q <= rdata_q;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = !out_hit_o ? '0 : rd_fresh_q ? rdata_q : rbuf_q;

  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o &&
      $stable({out_addr_o, out_id_o, out_set_o, out_hit_o, out_data_o, out_error_o}));

endmodule

`default_nettype wire

/* logic/icache_lookup.sv */
/*
 * Set-associative instruction cache lookup
 * Tag stage with one way per set, followed by the data stage
 */
`default_nettype none

module icache_lookup #(
  parameter int unsigned SET_COUNT   = icache_pkg::DefSetCount,
  parameter int unsigned LINE_COUNT  = icache_pkg::DefLineCount,
  parameter int unsigned LINE_WIDTH  = icache_pkg::DefLineWidth,
  parameter int unsigned FETCH_AW    = icache_pkg::DefFetchAw,
  parameter int unsigned ID_WIDTH    = icache_pkg::DefIdWidth,
  localparam int unsigned LINE_ALIGN  = $clog2(LINE_WIDTH / 8),
  localparam int unsigned COUNT_ALIGN = $clog2(LINE_COUNT),
  localparam int unsigned SET_ALIGN   = $clog2(SET_COUNT),
  localparam int unsigned TAG_WIDTH   =
    icache_pkg::tag_width(FETCH_AW, LINE_WIDTH, LINE_COUNT)
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic [FETCH_AW-1:0]     in_addr_i,
  input  logic [ID_WIDTH-1:0]     in_id_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output logic [FETCH_AW-1:0]     out_addr_o,
  output logic [ID_WIDTH-1:0]     out_id_o,
  output logic [SET_ALIGN-1:0]    out_set_o,
  output logic                    out_hit_o,
  output logic [LINE_WIDTH-1:0]   out_data_o,
  output logic                    out_error_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  input  logic [COUNT_ALIGN-1:0]  write_addr_i,
  input  logic [SET_ALIGN-1:0]    write_set_i,
  input  logic [TAG_WIDTH-1:0]    write_tag_i,
  input  logic [LINE_WIDTH-1:0]   write_data_i,
  input  logic                    write_error_i,
  input  logic                    write_valid_i,
  output logic                    write_ready_o,
  output logic                    event_hit_o,
  output logic                    event_miss_o
);

  icache_pkg::tag_op_e    tag_op;
  logic [COUNT_ALIGN-1:0] tag_index;
  logic [SET_COUNT-1:0]   set_enable;
  logic [FETCH_AW-1:0]    req_addr;
  logic [ID_WIDTH-1:0]    req_id;
  logic                   req_valid;
  logic                   req_ready;
  logic [SET_COUNT-1:0]   way_hit;
  logic [SET_COUNT-1:0]   way_error;
  logic                   tag_valid;
  logic                   tag_ready;
  logic                   tag_hit;
  logic [SET_ALIGN-1:0]   tag_set;
  logic                   tag_error;
  logic                   refill_valid;

  // Refill accepted this cycle
  assign refill_valid = write_valid_i && write_ready_o;

  icache_tag_ctrl #(
    .SET_COUNT (SET_COUNT), .LINE_COUNT (LINE_COUNT), .LINE_WIDTH (LINE_WIDTH),
    .FETCH_AW  (FETCH_AW),  .ID_WIDTH   (ID_WIDTH)
  ) tag_ctrl_i (
    .clk_i, .rst_ni, .flush_i, .in_addr_i, .in_id_i, .in_valid_i, .in_ready_o,
    .write_valid_i, .write_addr_i, .write_set_i, .write_ready_o,
    .stage_ready_i (req_ready),
    .tag_op_o      (tag_op),
    .tag_index_o   (tag_index),
    .set_enable_o  (set_enable),
    .req_addr_o    (req_addr),
    .req_id_o      (req_id),
    .req_valid_o   (req_valid)
  );

  for (genvar s = 0; s < SET_COUNT; s++) begin : gen_way
    icache_tag_way #(
      .LINE_COUNT (LINE_COUNT), .LINE_WIDTH (LINE_WIDTH), .FETCH_AW (FETCH_AW)
    ) way_i (
      .clk_i, .rst_ni,
      .tag_op_i    (tag_op),
      .tag_index_i (tag_index),
      .enable_i    (set_enable[s]),
      .wr_tag_i    (write_tag_i),
      .wr_error_i  (write_error_i),
      .req_addr_i  (req_addr),
      .way_hit_o   (way_hit[s]),
      .way_error_o (way_error[s])
    );
  end

  icache_hit_select #(
    .SET_COUNT (SET_COUNT), .LINE_COUNT (LINE_COUNT)
  ) hit_select_i (
    .clk_i, .rst_ni,
    .way_hit_i      (way_hit),
    .way_error_i    (way_error),
    .req_valid_i    (req_valid),
    .req_index_i    (req_addr[LINE_ALIGN +: COUNT_ALIGN]),
    .refill_valid_i (refill_valid),
    .refill_index_i (write_addr_i),
    .refill_set_i   (write_set_i),
    .tag_ready_i    (tag_ready),
    .tag_valid_o    (tag_valid),
    .hit_o          (tag_hit),
    .hit_set_o      (tag_set),
    .error_o        (tag_error),
    .stage_ready_o  (req_ready),
    .event_hit_o, .event_miss_o
  );

  icache_data_stage #(
    .SET_COUNT (SET_COUNT), .LINE_COUNT (LINE_COUNT), .LINE_WIDTH (LINE_WIDTH),
    .FETCH_AW  (FETCH_AW),  .ID_WIDTH   (ID_WIDTH)
  ) data_stage_i (
    .clk_i, .rst_ni,
    .tag_valid_i    (tag_valid),
    .tag_ready_o    (tag_ready),
    .hit_i          (tag_hit),
    .hit_set_i      (tag_set),
    .error_i        (tag_error),
    .req_addr_i     (req_addr),
    .req_id_i       (req_id),
    .refill_valid_i (refill_valid),
    .refill_index_i (write_addr_i),
    .refill_set_i   (write_set_i),
    .write_data_i,
    .out_addr_o, .out_id_o, .out_set_o, .out_hit_o, .out_data_o, .out_error_o,
    .out_valid_o, .out_ready_i
  );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
/*
 * Testbench clock and reset
 * Free-running clock and an active-low reset held for a fixed cycle count
 */
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release just after a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/tb_icache_lookup.sv */
/*
 * Testbench for the instruction cache lookup
 * Applies a table of refills, lookups and flushes and checks every output
 */
`default_nettype none

module tb_icache_lookup;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SET_COUNT  = icache_pkg::DefSetCount;
  localparam int LINE_COUNT = icache_pkg::DefLineCount;
  localparam int LINE_WIDTH = icache_pkg::DefLineWidth;
  localparam int FETCH_AW   = icache_pkg::DefFetchAw;
  localparam int ID_WIDTH   = icache_pkg::DefIdWidth;
  localparam int OFFSET_W   = $clog2(LINE_WIDTH / 8);
  localparam int INDEX_W    = $clog2(LINE_COUNT);
  localparam int SET_W      = $clog2(SET_COUNT);
  localparam int TAG_W      = FETCH_AW - OFFSET_W - INDEX_W;
  localparam int TIMEOUT    = 200;

  typedef enum logic [1:0] {OP_REFILL, OP_LOOKUP, OP_FLUSH} op_e;

  typedef struct packed {
    op_e                   op;
    logic [FETCH_AW-1:0]   addr;
    logic [SET_W-1:0]      set;
    logic [LINE_WIDTH-1:0] data;
    logic                  err;
  } stim_t;

  typedef struct packed {
    logic [FETCH_AW-1:0]   addr;
    logic [ID_WIDTH-1:0]   id;
    logic                  hit;
    logic [SET_W-1:0]      set;
    logic [LINE_WIDTH-1:0] data;
    logic                  err;
  } expect_t;

  logic                  clk;
  logic                  rst_n;
  logic                  flush;
  logic [FETCH_AW-1:0]   in_addr;
  logic [ID_WIDTH-1:0]   in_id;
  logic                  in_valid;
  logic                  in_ready;
  logic [FETCH_AW-1:0]   out_addr;
  logic [ID_WIDTH-1:0]   out_id;
  logic [SET_W-1:0]      out_set;
  logic                  out_hit;
  logic [LINE_WIDTH-1:0] out_data;
  logic                  out_error;
  logic                  out_valid;
  logic                  out_ready;
  logic [INDEX_W-1:0]    write_addr;
  logic [SET_W-1:0]      write_set;
  logic [TAG_W-1:0]      write_tag;
  logic [LINE_WIDTH-1:0] write_data;
  logic                  write_error;
  logic                  write_valid;
  logic                  write_ready;
  logic                  event_hit;
  logic                  event_miss;

  // Reference cache contents
  logic                  model_valid [SET_COUNT][LINE_COUNT];
  logic [TAG_W-1:0]      model_tag   [SET_COUNT][LINE_COUNT];
  logic [LINE_WIDTH-1:0] model_data  [SET_COUNT][LINE_COUNT];
  logic                  model_err   [SET_COUNT][LINE_COUNT];

  stim_t               stim_q [$];
  expect_t             exp_q  [$];
  logic [ID_WIDTH-1:0] next_id;
  int                  seed = 32'h247a;
  int                  issued;
  int                  received;
  int                  exp_hits;
  int                  exp_misses;
  int                  hit_events;
  int                  miss_events;

  tb_clock_gen #(.PERIOD_NS (8), .RESET_CYCLES (16)) clock_gen_i (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  icache_lookup #(
    .SET_COUNT (SET_COUNT), .LINE_COUNT (LINE_COUNT), .LINE_WIDTH (LINE_WIDTH),
    .FETCH_AW  (FETCH_AW),  .ID_WIDTH   (ID_WIDTH)
  ) dut_i (
    .clk_i (clk), .rst_ni (rst_n), .flush_i (flush),
    .in_addr_i (in_addr), .in_id_i (in_id), .in_valid_i (in_valid), .in_ready_o (in_ready),
    .out_addr_o (out_addr), .out_id_o (out_id), .out_set_o (out_set), .out_hit_o (out_hit),
    .out_data_o (out_data), .out_error_o (out_error), .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .write_addr_i (write_addr), .write_set_i (write_set), .write_tag_i (write_tag),
    .write_data_i (write_data), .write_error_i (write_error), .write_valid_i (write_valid),
    .write_ready_o (write_ready),
    .event_hit_o (event_hit), .event_miss_o (event_miss)
  );

  // ------------------------------------------------------------
  // Reporting
  // ------------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("=== FAIL ===");
    $display("%s", msg);
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch at %0t ns: %s is %0h, expected %0h",
                         $time, what, actual, expected));
    end
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic logic [INDEX_W-1:0] line_index(input logic [FETCH_AW-1:0] addr);
    return addr[OFFSET_W +: INDEX_W];
  endfunction

  function automatic logic [TAG_W-1:0] line_tag(input logic [FETCH_AW-1:0] addr);
    return addr[FETCH_AW-1 : OFFSET_W + INDEX_W];
  endfunction

  // First valid set with a matching tag wins and a miss predicts all zero
  function automatic expect_t predict(input logic [FETCH_AW-1:0] addr,
                                      input logic [ID_WIDTH-1:0] id);
    expect_t            exp;
    logic [INDEX_W-1:0] idx;
    idx = line_index(addr);
    exp = '0;
    exp.addr = addr;
    exp.id = id;
    for (int s = 0; s < SET_COUNT; s++) begin
      if (!exp.hit && model_valid[s][idx] && model_tag[s][idx] == line_tag(addr)) begin
        exp.hit = 1'b1;
        exp.set = SET_W'(s);
        exp.data = model_data[s][idx];
        exp.err = model_err[s][idx];
      end
    end
    return exp;
  endfunction

  task automatic clear_model();
    for (int s = 0; s < SET_COUNT; s++) begin
      for (int l = 0; l < LINE_COUNT; l++) begin
        model_valid[s][l] = 1'b0;
      end
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------
  task automatic add_entry(input op_e op, input logic [FETCH_AW-1:0] addr, input int set,
                           input logic [LINE_WIDTH-1:0] data, input logic err);
    stim_t entry;
    entry.op = op;
    entry.addr = addr;
    entry.set = SET_W'(set);
    entry.data = data;
    entry.err = err;
    stim_q.push_back(entry);
  endtask

  task automatic build_table();
    // Empty cache after reset
    add_entry(OP_LOOKUP, 32'h0000_0100, 0, '0, 1'b0);
    add_entry(OP_LOOKUP, 32'h1234_5678, 0, '0, 1'b0);
    // Single lines, looked up at several offsets
    add_entry(OP_REFILL, 32'h0000_1040, 2, 64'hA5A5_0001_DEAD_BEEF, 1'b0);
    add_entry(OP_LOOKUP, 32'h0000_1040, 0, '0, 1'b0);
    add_entry(OP_LOOKUP, 32'h0000_1047, 0, '0, 1'b0);
    add_entry(OP_REFILL, 32'h0000_2088, 1, 64'h0123_4567_89AB_CDEF, 1'b1);
    add_entry(OP_LOOKUP, 32'h0000_208C, 0, '0, 1'b0);
    // One tag per set at the same index, then a fifth tag
    for (int s = 0; s < SET_COUNT; s++) begin
      add_entry(OP_REFILL, {16'(s + 1), 16'h0028}, s, {32'hC0DE_0000, 32'(s)}, 1'b0);
    end
    for (int s = 0; s <= SET_COUNT; s++) begin
      add_entry(OP_LOOKUP, {16'(s + 1), 16'h002C}, 0, '0, 1'b0);
    end
    // Mixed burst of hits and misses
    for (int k = 0; k < 12; k++) begin
      if (k % 3 == 0) add_entry(OP_LOOKUP, 32'h0000_1040 + 32'(k % 8), 0, '0, 1'b0);
      else if (k % 3 == 1) add_entry(OP_LOOKUP, {16'(k % 4 + 1), 16'h0028}, 0, '0, 1'b0);
      else add_entry(OP_LOOKUP, 32'h00F0_0000 + 32'(k * 8), 0, '0, 1'b0);
    end
    add_entry(OP_FLUSH, '0, 0, '0, 1'b0);
    add_entry(OP_LOOKUP, 32'h0000_1040, 0, '0, 1'b0);
    add_entry(OP_LOOKUP, 32'h0002_0028, 0, '0, 1'b0);
    add_entry(OP_LOOKUP, 32'h0000_208C, 0, '0, 1'b0);
    add_entry(OP_REFILL, 32'h0002_0028, 3, 64'h5555_AAAA_0F0F_F0F0, 1'b1);
    for (int k = 0; k < 8; k++) begin
      add_entry(OP_LOOKUP, {16'(k % 2 + 2), 16'h0028 + 16'(k)}, 0, '0, 1'b0);
    end
  endtask

  // ------------------------------------------------------------
  // Drivers that start and end 1 ns after a rising edge
  // ------------------------------------------------------------
  task automatic send_lookup(input logic [FETCH_AW-1:0] addr);
    int      cycles;
    logic    accepted;
    expect_t exp;
    exp = predict(addr, next_id);
    in_addr = addr;
    in_id = next_id;
    in_valid = 1'b1;
    cycles = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      if (accepted) begin
        exp_q.push_back(exp);
        issued++;
        if (exp.hit) exp_hits++;
        else exp_misses++;
      end
      @(posedge clk);
      #1;
      cycles++;
      if (!accepted && cycles > TIMEOUT) begin
        fail_run($sformatf("Timeout at %0t ns: lookup was never accepted", $time));
      end
    end
    in_valid = 1'b0;
    next_id = next_id + 1'b1;
  endtask

  task automatic send_refill(input stim_t entry);
    int   cycles;
    logic accepted;
    write_addr = line_index(entry.addr);
    write_tag = line_tag(entry.addr);
    write_set = entry.set;
    write_data = entry.data;
    write_error = entry.err;
    write_valid = 1'b1;
    cycles = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = write_ready;
      @(posedge clk);
      #1;
      cycles++;
      if (!accepted && cycles > TIMEOUT) begin
        fail_run($sformatf("Timeout at %0t ns: refill was never accepted", $time));
      end
    end
    write_valid = 1'b0;
    model_valid[entry.set][write_addr] = 1'b1;
    model_tag[entry.set][write_addr] = write_tag;
    model_data[entry.set][write_addr] = entry.data;
    model_err[entry.set][write_addr] = entry.err;
  endtask

  task automatic pulse_flush();
    int cycles;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    clear_model();
    check_equal(64'(write_ready), 64'(0), "write_ready_o at sweep start");
    cycles = 0;
    while (!write_ready) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) fail_run($sformatf("Timeout at %0t ns: sweep never ended", $time));
    end
  endtask

  // Wait until every issued lookup has left the DUT
  task automatic drain_outputs();
    int cycles;
    cycles = 0;
    while (received != issued) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) fail_run($sformatf("Timeout at %0t ns: outputs missing", $time));
    end
  endtask

  // ------------------------------------------------------------
  // Output collection and event counting
  // ------------------------------------------------------------
  always @(negedge clk) begin : collect_outputs
    expect_t exp;
    if (rst_n) begin
      if (event_hit) hit_events++;
      if (event_miss) miss_events++;
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) fail_run("Output transfer arrived with no lookup pending");
        exp = exp_q.pop_front();
        check_equal(64'(out_addr), 64'(exp.addr), "out_addr_o");
        check_equal(64'(out_id), 64'(exp.id), "out_id_o");
        check_equal(64'(out_hit), 64'(exp.hit), "out_hit_o");
        if (exp.hit) check_equal(64'(out_set), 64'(exp.set), "out_set_o");
        check_equal(64'(out_data), 64'(exp.data), "out_data_o");
        check_equal(64'(out_error), 64'(exp.err), "out_error_o");
        received++;
      end
    end
  end

  // Random back-pressure
  always @(posedge clk) begin
    #1;
    out_ready = (($random(seed) & 3) != 0);
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin : main_sequence
    int cycles;
    flush = 1'b0;
    in_addr = '0;
    in_id = '0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    write_addr = '0;
    write_set = '0;
    write_tag = '0;
    write_data = '0;
    write_error = 1'b0;
    write_valid = 1'b0;
    next_id = '0;
    clear_model();
    build_table();

    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) fail_run("Reset was never released");
    end while (!rst_n);
    #1;
    check_equal(64'(in_ready), 64'(0), "in_ready_o after reset");
    check_equal(64'(write_ready), 64'(0), "write_ready_o after reset");
    check_equal(64'(out_valid), 64'(0), "out_valid_o after reset");
    check_equal(64'({event_hit, event_miss}), 64'(0), "event pulses after reset");

    cycles = 0;
    while (!in_ready) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) fail_run("in_ready_o never rose after the reset sweep");
    end

    foreach (stim_q[i]) begin
      case (stim_q[i].op)
        OP_LOOKUP: send_lookup(stim_q[i].addr);
        OP_REFILL: begin
          drain_outputs();
          send_refill(stim_q[i]);
        end
        default: begin
          drain_outputs();
          pulse_flush();
        end
      endcase
    end
    drain_outputs();
    // No output beyond the issued lookups
    check_equal(64'(out_valid), 64'(0), "out_valid_o after the last output");

    check_equal(64'(hit_events), 64'(exp_hits), "event_hit_o count");
    check_equal(64'(miss_events), 64'(exp_misses), "event_miss_o count");
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* icache_lookup.f */
logic/icache_pkg.sv
logic/icache_tag_ctrl.sv
logic/icache_tag_way.sv
logic/icache_hit_select.sv
logic/icache_data_stage.sv
logic/icache_lookup.sv
verif/tb_clock_gen.sv
verif/tb_icache_lookup.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the cache lookup testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_icache_lookup -Mdir obj_dir -f icache_lookup.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/Vtb_icache_lookup)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "=== PASS ==="; then
  exit 0
fi

echo "Simulation did not report success"
exit 1
